// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_mips_mem
FILELIST = vlog.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "No errors" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== data_ram.sv ====
`timescale 1ns/1ns
`include "mips_params.svh"

module data_ram (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    input  logic [3:0]  be,
    output logic [31:0] rdata
);

    logic [31:0] mem [`DM_WORDS];
    logic [11:0] idx;

    assign idx   = addr[13:2];
    assign rdata = mem[idx];

    // each enabled lane writes its own byte
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                mem[idx][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

    // the stage only enables RAM writes inside the data region
    assert property (@(posedge clk) disable iff (rst)
        (|be) |-> (addr <= `DM_LAST))
        else $error("RAM write outside data region at %h", addr);

endmodule

// ==== instr_pkg.sv ====
package instr_pkg;

    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_jal     = 6'h03,
        op_addiu   = 6'h09,
        op_lui     = 6'h0f,
        op_lb      = 6'h20,
        op_lh      = 6'h21,
        op_lw      = 6'h23,
        op_lbu     = 6'h24,
        op_lhu     = 6'h25,
        op_sb      = 6'h28,
        op_sh      = 6'h29,
        op_sw      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        fn_syscall = 6'h0c,
        fn_mfhi    = 6'h10
    } funct_e;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fmt_t;

    // the same instruction word read as register or immediate format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_word_u;

endpackage

// ==== mem_ctrl_decode.sv ====
`timescale 1ns/1ns

module mem_ctrl_decode import instr_pkg::*, mem_pkg::*; (
    input  instr_word_u   instr,
    output logic          mem_we,
    output logic          load,
    output logic          sign_ext,
    output logic          syscall,
    output logic          reg_we,
    output access_width_e width,
    output wb_src_e       wb_src,
    output wb_dst_e       wb_dst
);

    always_comb begin
        mem_we   = 1'b0;
        load     = 1'b0;
        sign_ext = 1'b0;
        syscall  = 1'b0;
        reg_we   = 1'b0;
        width    = aw_none;
        wb_src   = src_alu;
        wb_dst   = dst_rt;

        case (instr.i_fmt.op)
            op_lw, op_lh, op_lhu, op_lb, op_lbu: begin
                load     = 1'b1;
                reg_we   = 1'b1;
                wb_src   = src_mem;
                sign_ext = (instr.i_fmt.op == op_lh) || (instr.i_fmt.op == op_lb);
                if (instr.i_fmt.op == op_lw) begin
                    width = aw_word;
                end else if (instr.i_fmt.op == op_lh || instr.i_fmt.op == op_lhu) begin
                    width = aw_half;
                end else begin
                    width = aw_byte;
                end
            end
            op_sw: begin
                mem_we = 1'b1;
                width  = aw_word;
            end
            op_sh: begin
                mem_we = 1'b1;
                width  = aw_half;
            end
            op_sb: begin
                mem_we = 1'b1;
                width  = aw_byte;
            end
            op_lui: begin
                reg_we = 1'b1;
                wb_src = src_imm;
            end
            op_jal: begin
                reg_we = 1'b1;
                wb_src = src_pc8;
                wb_dst = dst_ra;
            end
            op_addiu: begin
                reg_we = 1'b1;
            end
            op_special: begin
                case (instr.r_fmt.funct)
                    fn_syscall: syscall = 1'b1;
                    fn_mfhi: begin
                        reg_we = 1'b1;
                        wb_src = src_mlu;
                        wb_dst = dst_rd;
                    end
                    // remaining special functs are ALU ops writing rd
                    default: begin
                        reg_we = 1'b1;
                        wb_dst = dst_rd;
                    end
                endcase
            end
            default: ;
        endcase
    end

    always_comb begin
        if (load || mem_we) begin
            assert (width != aw_none)
                else $error("memory access decoded without a width");
        end
    end

endmodule

// ==== mem_pkg.sv ====
package mem_pkg;

    // width of a memory access where none means the instruction does not touch memory
    typedef enum logic [1:0] {
        aw_none = 2'd0,
        aw_word = 2'd1,
        aw_half = 2'd2,
        aw_byte = 2'd3
    } access_width_e;

    typedef enum logic [2:0] {
        src_alu = 3'd0,
        src_mem = 3'd1,
        src_imm = 3'd2,
        src_pc8 = 3'd3,
        src_mlu = 3'd4
    } wb_src_e;

    // dst_ra is the link register used by jal
    typedef enum logic [1:0] {
        dst_rt = 2'd0,
        dst_rd = 2'd1,
        dst_ra = 2'd2
    } wb_dst_e;

endpackage

// ==== mem_stage.sv ====
`timescale 1ns/1ns
`include "mips_params.svh"

module mem_stage import instr_pkg::*, mem_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    input  instr_word_u instr,
    input  logic [31:0] pc,
    input  logic [31:0] alu_res,
    input  logic [31:0] mlu_res,
    input  logic [31:0] rt_val,
    input  logic [31:0] imm32,
    input  logic [31:0] mem_rdata,
    output logic [31:0] mem_addr,
    output logic [31:0] mem_wdata,
    output logic [3:0]  be_dm,
    output logic [3:0]  be_dev,
    output logic        wb_valid,
    output logic [4:0]  wb_reg,
    output logic [31:0] wb_data,
    output logic [4:0]  exc_code,
    output logic [31:0] tb_out
);

    logic          mem_we, load, sign_ext, syscall, reg_we;
    access_width_e width;
    wb_src_e       wb_src;
    wb_dst_e       wb_dst;
    logic          in_dm, in_dev, in_tb, access, misaligned, bad_dev, store_ok;
    logic [4:0]    exc, lane_sh;
    logic [3:0]    lane_be, be_tb;
    logic [31:0]   read_word, lane_word, load_val, wb_data_d;
    logic [4:0]    wb_reg_d;

    mem_ctrl_decode u_decode (
        .instr    (instr),
        .mem_we   (mem_we),
        .load     (load),
        .sign_ext (sign_ext),
        .syscall  (syscall),
        .reg_we   (reg_we),
        .width    (width),
        .wb_src   (wb_src),
        .wb_dst   (wb_dst)
    );

    // --------------------
    // region and exception checks
    // --------------------
    assign mem_addr = alu_res;
    assign in_dm    = alu_res <= `DM_LAST;
    assign in_dev   = (alu_res >= `TIMER0_BASE && alu_res <= `TIMER0_BASE + `TIMER_LAST_OFS) ||
                      (alu_res >= `TIMER1_BASE && alu_res <= `TIMER1_BASE + `TIMER_LAST_OFS);
    assign in_tb    = alu_res == `TBOUT_ADDR;
    assign access   = load || mem_we;

    assign misaligned = (width == aw_word && alu_res[1:0] != 2'b00) ||
                        (width == aw_half && alu_res[0]);
    // timers take word accesses only and their count register is read-only
    assign bad_dev    = in_dev && (width != aw_word ||
                                   (mem_we && alu_res[3:2] == `TIMER_CNT_OFS));

    always_comb begin
        if (syscall) begin
            exc = `EXC_SYSCALL;
        end else if (access && (misaligned || !(in_dm || in_dev || in_tb) || bad_dev)) begin
            exc = mem_we ? `EXC_ADES : `EXC_ADEL;
        end else begin
            exc = `EXC_NONE;
        end
    end

    // --------------------
    // store lanes
    // --------------------
    assign lane_sh   = {alu_res[1:0], 3'b000};
    assign mem_wdata = rt_val << lane_sh;

    always_comb begin
        case (width)
            aw_word: lane_be = 4'b1111;
            aw_half: lane_be = alu_res[1] ? 4'b1100 : 4'b0011;
            aw_byte: lane_be = 4'b0001 << alu_res[1:0];
            default: lane_be = 4'b0000;
        endcase
    end

    assign store_ok = in_valid && mem_we && exc == `EXC_NONE;
    assign be_dm    = (store_ok && in_dm)  ? lane_be : 4'b0000;
    assign be_dev   = (store_ok && in_dev) ? lane_be : 4'b0000;
    assign be_tb    = (store_ok && in_tb)  ? lane_be : 4'b0000;

    // --------------------
    // load extension
    // --------------------
    // the test port is read back from the local register
    assign read_word = in_tb ? tb_out : mem_rdata;
    assign lane_word = read_word >> lane_sh;

    always_comb begin
        case (width)
            aw_half: load_val = sign_ext ? {{16{lane_word[15]}}, lane_word[15:0]}
                                         : {16'b0, lane_word[15:0]};
            aw_byte: load_val = sign_ext ? {{24{lane_word[7]}}, lane_word[7:0]}
                                         : {24'b0, lane_word[7:0]};
            default: load_val = read_word;
        endcase
    end

    always_comb begin
        case (wb_src)
            src_mem: wb_data_d = load_val;
            src_imm: wb_data_d = imm32;
            src_pc8: wb_data_d = pc + 32'd8;
            src_mlu: wb_data_d = mlu_res;
            default: wb_data_d = alu_res;
        endcase
    end

    always_comb begin
        if (!reg_we || exc != `EXC_NONE) begin
            wb_reg_d = 5'd0;
        end else begin
            case (wb_dst)
                dst_rd:  wb_reg_d = instr.r_fmt.rd;
                dst_ra:  wb_reg_d = 5'd31;
                default: wb_reg_d = instr.i_fmt.rt;
            endcase
        end
    end

    // --------------------
    // writeback register and test port
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
            tb_out   <= 32'd0;
        end else begin
            wb_valid <= in_valid;
            for (int i = 0; i < 4; i++) begin
                if (be_tb[i]) begin
                    tb_out[8*i +: 8] <= mem_wdata[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            wb_reg   <= wb_reg_d;
            wb_data  <= wb_data_d;
            exc_code <= exc;
        end
    end

    // a store reaches at most one of RAM, timers and test port
    assert property (@(posedge clk) disable iff (rst)
        $onehot0({|be_dm, |be_dev, |be_tb}))
        else $error("store enables more than one region");

endmodule

// ==== mips_mem_top.sv ====
`timescale 1ns/1ns
`include "mips_params.svh"

module mips_mem_top import instr_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    input  instr_word_u instr,
    input  logic [31:0] pc,
    input  logic [31:0] alu_res,
    input  logic [31:0] mlu_res,
    input  logic [31:0] rt_val,
    input  logic [31:0] imm32,
    output logic        wb_valid,
    output logic [4:0]  wb_reg,
    output logic [31:0] wb_data,
    output logic [4:0]  exc_code,
    output logic [31:0] tb_out,
    output logic        irq0,
    output logic        irq1
);

    logic [31:0] mem_addr, mem_wdata, mem_rdata;
    logic [31:0] ram_rdata, t0_rdata, t1_rdata;
    logic [3:0]  be_dm, be_dev;
    logic        dev_win, sel0, sel1;

    mem_stage u_stage (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .instr     (instr),
        .pc        (pc),
        .alu_res   (alu_res),
        .mlu_res   (mlu_res),
        .rt_val    (rt_val),
        .imm32     (imm32),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .be_dm     (be_dm),
        .be_dev    (be_dev),
        .wb_valid  (wb_valid),
        .wb_reg    (wb_reg),
        .wb_data   (wb_data),
        .exc_code  (exc_code),
        .tb_out    (tb_out)
    );

    data_ram u_ram (
        .clk   (clk),
        .rst   (rst),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .be    (be_dm),
        .rdata (ram_rdata)
    );

    // both timer windows share one 32-byte block and bit 4 picks the timer
    assign dev_win = (mem_addr & 32'hffff_ffe0) == `TIMER0_BASE;
    assign sel0    = dev_win && !mem_addr[4];
    assign sel1    = dev_win && mem_addr[4];

    timer_dev u_timer0 (
        .clk    (clk),
        .rst    (rst),
        .sel    (sel0),
        .offset (mem_addr[3:2]),
        .wdata  (mem_wdata),
        .we     (|be_dev),
        .rdata  (t0_rdata),
        .irq    (irq0)
    );

    timer_dev u_timer1 (
        .clk    (clk),
        .rst    (rst),
        .sel    (sel1),
        .offset (mem_addr[3:2]),
        .wdata  (mem_wdata),
        .we     (|be_dev),
        .rdata  (t1_rdata),
        .irq    (irq1)
    );

    always_comb begin
        if (mem_addr <= `DM_LAST) begin
            mem_rdata = ram_rdata;
        end else if (sel0) begin
            mem_rdata = t0_rdata;
        end else if (sel1) begin
            mem_rdata = t1_rdata;
        end else begin
            mem_rdata = 32'd0;
        end
    end

endmodule

// ==== mips_params.svh ====
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// --------------------
// address map
// --------------------
`define DM_LAST         32'h0000_2fff
`define DM_WORDS        3072

// each timer window holds three word registers
`define TIMER0_BASE     32'h0000_7f00
`define TIMER1_BASE     32'h0000_7f10
`define TIMER_LAST_OFS  32'h0000_000b
`define TIMER_CNT_OFS   2'd2

`define TBOUT_ADDR      32'h0000_7f20

// --------------------
// exception codes
// --------------------
`define EXC_NONE        5'd0
`define EXC_ADEL        5'd4
`define EXC_ADES        5'd5
`define EXC_SYSCALL     5'd8

`endif

// ==== tb_mips_mem.sv ====
`timescale 1ns/1ns
`include "mips_params.svh"

module tb_mips_mem import instr_pkg::*; ();

    // the stimulus runs for about 225 cycles and the limit leaves a wide margin
    localparam int TIMEOUT_CYCLES = 2000;
    localparam logic [31:0] RAM_BASE = 32'h0000_2fc0;
    localparam logic [31:0] PRESET = 32'd20;

    logic        clk;
    logic        rst;
    logic        in_valid;
    instr_word_u instr;
    logic [31:0] pc;
    logic [31:0] alu_res;
    logic [31:0] mlu_res;
    logic [31:0] rt_val;
    logic [31:0] imm32;
    logic        wb_valid;
    logic [4:0]  wb_reg;
    logic [31:0] wb_data;
    logic [4:0]  exc_code;
    logic [31:0] tb_out;
    logic        irq0;
    logic        irq1;

    // reference model state
    logic [31:0] shadow [`DM_WORDS];
    logic [31:0] m_tb;
    logic        t0_en;
    logic [31:0] t0_preset;
    logic [31:0] t0_cnt;

    // expected results of the strobe being driven
    logic [4:0]  exp_reg;
    logic [4:0]  exp_exc;
    logic [31:0] exp_data;
    logic        exp_chk;
    logic        exp_tb_we;
    logic [31:0] exp_tb_val;
    logic        exp_t0_we;
    logic [1:0]  exp_t0_ofs;
    logic [31:0] exp_t0_val;
    int          cycles;

    mips_mem_top u_dut (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .instr    (instr),
        .pc       (pc),
        .alu_res  (alu_res),
        .mlu_res  (mlu_res),
        .rt_val   (rt_val),
        .imm32    (imm32),
        .wb_valid (wb_valid),
        .wb_reg   (wb_reg),
        .wb_data  (wb_data),
        .exc_code (exc_code),
        .tb_out   (tb_out),
        .irq0     (irq0),
        .irq1     (irq1)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            stop_on_error("timeout: the test sequence did not finish within the cycle limit");
        end
    end

    // --------------------
    // reference model
    // --------------------
    function automatic int op_bytes(input logic [5:0] op);
        if (op inside {op_lw, op_sw}) begin
            return 4;
        end else if (op inside {op_lh, op_lhu, op_sh}) begin
            return 2;
        end
        return 1;
    endfunction

    function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] val,
                                                input int nbytes, input logic [1:0] ofs);
        logic [31:0] res;
        res = old;
        for (int i = 0; i < nbytes; i++) begin
            res[8*(ofs+i) +: 8] = val[8*i +: 8];
        end
        return res;
    endfunction

    function automatic logic [31:0] model_read(input logic [31:0] addr);
        if (addr <= `DM_LAST) begin
            return shadow[addr[13:2]];
        end else if ((addr & 32'hffff_fff0) == `TIMER0_BASE) begin
            case (addr[3:2])
                2'd0:    return {31'd0, t0_en};
                2'd1:    return t0_preset;
                2'd2:    return t0_cnt;
                default: return 32'd0;
            endcase
        end else if (addr == `TBOUT_ADDR) begin
            return m_tb;
        end
        // timer 1 is never written, so all of its registers read 0
        return 32'd0;
    endfunction

    function automatic logic [4:0] model_exc(input bit is_load, input bit is_store,
                                             input bit is_sys, input int nbytes,
                                             input logic [31:0] addr);
        bit in_timer;
        bit known;
        bit bad;
        in_timer = (addr >= `TIMER0_BASE && addr < `TIMER0_BASE + 32'd12) ||
                   (addr >= `TIMER1_BASE && addr < `TIMER1_BASE + 32'd12);
        known    = addr <= `DM_LAST || in_timer || addr == `TBOUT_ADDR;
        bad      = (nbytes == 4 && addr[1:0] != 2'd0) || (nbytes == 2 && addr[0]) || !known ||
                   (in_timer && nbytes != 4) || (in_timer && is_store && addr[3:2] == 2'd2);
        if (is_sys) begin
            return `EXC_SYSCALL;
        end else if ((is_load || is_store) && bad) begin
            return is_store ? `EXC_ADES : `EXC_ADEL;
        end
        return `EXC_NONE;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            t0_en     <= 1'b0;
            t0_preset <= 32'd0;
            t0_cnt    <= 32'd0;
        end else begin
            if (in_valid && exp_t0_we && exp_t0_ofs == 2'd0) begin
                t0_en <= exp_t0_val[0];
            end
            if (in_valid && exp_t0_we && exp_t0_ofs == 2'd1) begin
                t0_preset <= exp_t0_val;
                t0_cnt    <= exp_t0_val;
            end else if (t0_en && t0_cnt != 32'd0) begin
                t0_cnt <= t0_cnt - 32'd1;
            end
        end
    end

    // --------------------
    // stimulus
    // --------------------
    task automatic issue(input logic [5:0] op, input logic [5:0] funct, input logic [4:0] rt,
                         input logic [4:0] rd, input logic [31:0] addr,
                         input logic [31:0] rt_v);
        bit          is_load;
        bit          is_store;
        bit          is_sys;
        int          nbytes;
        logic [4:0]  dst;
        logic [4:0]  exc;
        logic [31:0] data;
        logic [31:0] lane;
        @(negedge clk);
        pc       = $urandom & 32'hffff_fffc;
        mlu_res  = $urandom;
        imm32    = $urandom;
        is_load  = op inside {op_lw, op_lh, op_lhu, op_lb, op_lbu};
        is_store = op inside {op_sw, op_sh, op_sb};
        is_sys   = op == op_special && funct == fn_syscall;
        nbytes   = op_bytes(op);
        dst      = 5'd0;
        data     = addr;
        lane     = model_read({addr[31:2], 2'b00}) >> (8 * addr[1:0]);
        if (is_load) begin
            dst = rt;
            if (nbytes == 2) begin
                data = (op == op_lh) ? {{16{lane[15]}}, lane[15:0]} : {16'd0, lane[15:0]};
            end else if (nbytes == 1) begin
                data = (op == op_lb) ? {{24{lane[7]}}, lane[7:0]} : {24'd0, lane[7:0]};
            end else begin
                data = lane;
            end
        end else if (op == op_lui) begin
            dst  = rt;
            data = imm32;
        end else if (op == op_jal) begin
            dst  = 5'd31;
            data = pc + 32'd8;
        end else if (op == op_addiu) begin
            dst = rt;
        end else if (op == op_special && !is_sys) begin
            dst  = rd;
            data = (funct == fn_mfhi) ? mlu_res : addr;
        end
        exc        = model_exc(is_load, is_store, is_sys, nbytes, addr);
        exp_exc    = exc;
        exp_reg    = (exc != `EXC_NONE) ? 5'd0 : dst;
        exp_data   = data;
        exp_chk    = exp_reg != 5'd0;
        exp_tb_we  = 1'b0;
        exp_t0_we  = 1'b0;
        exp_t0_ofs = addr[3:2];
        exp_t0_val = rt_v;
        if (is_store && exc == `EXC_NONE) begin
            if (addr <= `DM_LAST) begin
                shadow[addr[13:2]] = merge_lanes(shadow[addr[13:2]], rt_v, nbytes, addr[1:0]);
            end else if (addr == `TBOUT_ADDR) begin
                m_tb       = merge_lanes(m_tb, rt_v, nbytes, addr[1:0]);
                exp_tb_we  = 1'b1;
                exp_tb_val = m_tb;
            end else if ((addr & 32'hffff_fff0) == `TIMER0_BASE) begin
                exp_t0_we = 1'b1;
            end
        end
        instr.r_fmt.op    = op;
        instr.r_fmt.rs    = 5'($urandom_range(0, 31));
        instr.r_fmt.rt    = rt;
        instr.r_fmt.rd    = rd;
        instr.r_fmt.shamt = 5'd0;
        instr.r_fmt.funct = funct;
        alu_res  = addr;
        rt_val   = rt_v;
        in_valid = 1'b1;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            in_valid  = 1'b0;
            exp_chk   = 1'b0;
            exp_tb_we = 1'b0;
            exp_t0_we = 1'b0;
        end
    endtask

    function automatic logic [5:0] random_mem_op();
        case ($urandom_range(0, 7))
            0:       return op_sw;
            1:       return op_sh;
            2:       return op_sb;
            3:       return op_lw;
            4:       return op_lh;
            5:       return op_lhu;
            6:       return op_lb;
            default: return op_lbu;
        endcase
    endfunction

    function automatic logic [31:0] random_ram_addr(input int nbytes);
        logic [31:0] a;
        a = RAM_BASE + $urandom_range(0, 63);
        return a & ~(nbytes - 1);
    endfunction

    function automatic logic [4:0] random_reg();
        return 5'($urandom_range(1, 31));
    endfunction

    initial begin
        logic [5:0] op;
        void'($urandom(65));
        rst        = 1'b1;
        in_valid   = 1'b0;
        instr      = '0;
        pc         = 32'd0;
        alu_res    = 32'd0;
        mlu_res    = 32'd0;
        rt_val     = 32'd0;
        imm32      = 32'd0;
        m_tb       = 32'd0;
        exp_reg    = 5'd0;
        exp_exc    = 5'd0;
        exp_data   = 32'd0;
        exp_chk    = 1'b0;
        exp_tb_we  = 1'b0;
        exp_tb_val = 32'd0;
        exp_t0_we  = 1'b0;
        exp_t0_ofs = 2'd0;
        exp_t0_val = 32'd0;
        cycles     = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // fill the top 16 RAM words, then mix stores and loads of every width
        for (int k = 0; k < 16; k++) begin
            issue(op_sw, 6'd0, random_reg(), 5'd0, RAM_BASE + 32'(4 * k), $urandom);
        end
        for (int k = 0; k < 100; k++) begin
            op = random_mem_op();
            issue(op, 6'd0, random_reg(), 5'd0, random_ram_addr(op_bytes(op)), $urandom);
        end
        idle(2);

        // --------------------
        // exceptions
        // --------------------
        issue(op_sw, 6'd0, random_reg(), 5'd0, RAM_BASE + 32'd1, $urandom);
        issue(op_sh, 6'd0, random_reg(), 5'd0, RAM_BASE + 32'd3, $urandom);
        issue(op_lw, 6'd0, random_reg(), 5'd0, RAM_BASE + 32'd2, 32'd0);
        issue(op_lh, 6'd0, random_reg(), 5'd0, RAM_BASE + 32'd5, 32'd0);
        issue(op_lw, 6'd0, random_reg(), 5'd0, 32'h0000_3000, 32'd0);
        issue(op_sw, 6'd0, random_reg(), 5'd0, 32'h0000_5000, $urandom);
        issue(op_sb, 6'd0, random_reg(), 5'd0, 32'h0000_7f0c, $urandom);
        issue(op_sw, 6'd0, random_reg(), 5'd0, `TIMER0_BASE + 32'd8, $urandom);
        issue(op_sb, 6'd0, random_reg(), 5'd0, `TIMER0_BASE + 32'd4, $urandom);
        issue(op_lb, 6'd0, random_reg(), 5'd0, `TIMER0_BASE, 32'd0);
        issue(op_lhu, 6'd0, random_reg(), 5'd0, `TIMER1_BASE + 32'd4, 32'd0);
        issue(op_special, fn_syscall, random_reg(), random_reg(), $urandom, 32'd0);
        issue(op_lw, 6'd0, random_reg(), 5'd0, RAM_BASE, 32'd0);
        issue(op_lw, 6'd0, random_reg(), 5'd0, RAM_BASE + 32'd4, 32'd0);
        issue(op_lw, 6'd0, random_reg(), 5'd0, `TIMER0_BASE + 32'd4, 32'd0);
        issue(op_lw, 6'd0, random_reg(), 5'd0, `TIMER0_BASE + 32'd8, 32'd0);
        idle(2);

        // non-memory writeback sources
        for (int k = 0; k < 3; k++) begin
            issue(op_addiu, 6'd0, random_reg(), 5'd0, $urandom, 32'd0);
            issue(op_special, 6'h21, random_reg(), random_reg(), $urandom, 32'd0);
            issue(op_lui, 6'd0, random_reg(), 5'd0, $urandom, 32'd0);
            issue(op_jal, 6'd0, 5'd0, 5'd0, $urandom, 32'd0);
            issue(op_special, fn_mfhi, random_reg(), random_reg(), $urandom, 32'd0);
        end

        // test output port
        issue(op_sw, 6'd0, random_reg(), 5'd0, `TBOUT_ADDR, $urandom);
        issue(op_sw, 6'd0, random_reg(), 5'd0, `TBOUT_ADDR, $urandom);
        issue(op_lw, 6'd0, random_reg(), 5'd0, `TBOUT_ADDR, 32'd0);
        idle(2);

        // --------------------
        // timer countdown
        // --------------------
        issue(op_sw, 6'd0, random_reg(), 5'd0, `TIMER0_BASE + 32'd4, PRESET);
        issue(op_sw, 6'd0, random_reg(), 5'd0, `TIMER0_BASE, 32'd1);
        idle(5);
        issue(op_lw, 6'd0, random_reg(), 5'd0, `TIMER0_BASE + 32'd8, 32'd0);
        issue(op_lw, 6'd0, random_reg(), 5'd0, `TIMER0_BASE + 32'd4, 32'd0);
        issue(op_lw, 6'd0, random_reg(), 5'd0, `TIMER0_BASE, 32'd0);
        issue(op_lw, 6'd0, random_reg(), 5'd0, `TIMER1_BASE + 32'd8, 32'd0);
        idle(1);
        while (!irq0) begin
            @(negedge clk);
        end
        idle(8);
        issue(op_lw, 6'd0, random_reg(), 5'd0, `TIMER0_BASE + 32'd8, 32'd0);
        idle(3);
        $display("No errors");
        $finish;
    end

    // --------------------
    // checks
    // --------------------
    assert property (@(posedge clk) rst |=> (!wb_valid && tb_out == 32'd0 && !irq0 && !irq1))
        else stop_on_error($sformatf("Mismatch at %0t: outputs not cleared by reset", $time));

    assert property (@(posedge clk) disable iff (rst) in_valid |=> wb_valid)
        else stop_on_error($sformatf("Mismatch at %0t: wb_valid missing after strobe", $time));

    assert property (@(posedge clk) disable iff (rst) !in_valid |=> !wb_valid)
        else stop_on_error($sformatf("Mismatch at %0t: wb_valid without strobe", $time));

    assert property (@(posedge clk) disable iff (rst)
        in_valid |=> (wb_reg == $past(exp_reg) && exc_code == $past(exp_exc)))
        else stop_on_error($sformatf("Mismatch at %0t: wb_reg or exc_code wrong", $time));

    assert property (@(posedge clk) disable iff (rst)
        (in_valid && exp_chk) |=> wb_data == $past(exp_data))
        else stop_on_error($sformatf("Mismatch at %0t: wb_data differs from model", $time));

    assert property (@(posedge clk) disable iff (rst)
        (in_valid && exp_tb_we) |=> tb_out == $past(exp_tb_val))
        else stop_on_error($sformatf("Mismatch at %0t: tb_out not updated by store", $time));

    assert property (@(posedge clk) disable iff (rst)
        !(in_valid && exp_tb_we) |=> $stable(tb_out))
        else stop_on_error($sformatf("Mismatch at %0t: tb_out changed without store", $time));

    // irq0 must rise once the model count has run down and stay high while enabled
    assert property (@(posedge clk) disable iff (rst) irq0 == (t0_en && t0_cnt == 32'd0))
        else stop_on_error($sformatf("Mismatch at %0t: irq0 differs from timer model", $time));

    assert property (@(posedge clk) disable iff (rst) !irq1)
        else stop_on_error($sformatf("Mismatch at %0t: irq1 raised", $time));

endmodule

// ==== timer_dev.sv ====
`timescale 1ns/1ns
`include "mips_params.svh"

module timer_dev (
    input  logic        clk,
    input  logic        rst,
    input  logic        sel,
    input  logic [1:0]  offset,
    input  logic [31:0] wdata,
    input  logic        we,
    output logic [31:0] rdata,
    output logic        irq
);

    logic        enable;
    logic [31:0] preset;
    logic [31:0] count;
    logic        wr;

    assign wr = sel && we;

    always_ff @(posedge clk) begin
        if (rst) begin
            enable <= 1'b0;
            preset <= 32'd0;
            count  <= 32'd0;
        end else begin
            if (wr && offset == 2'd0) begin
                enable <= wdata[0];
            end
            // writing the preset also reloads the count
            if (wr && offset == 2'd1) begin
                preset <= wdata;
                count  <= wdata;
            end else if (enable && count != 32'd0) begin
                count <= count - 32'd1;
            end
        end
    end

    always_comb begin
        case (offset)
            2'd0:    rdata = {31'd0, enable};
            2'd1:    rdata = preset;
            2'd2:    rdata = count;
            default: rdata = 32'd0;
        endcase
    end

    assign irq = enable && count == 32'd0;

    // the stage turns stores to the count register into exceptions
    assert property (@(posedge clk) disable iff (rst)
        wr |-> (offset != `TIMER_CNT_OFS))
        else $error("write reached timer count register");

endmodule

// ==== vlog.f ====
+incdir+.
instr_pkg.sv
mem_pkg.sv
mem_ctrl_decode.sv
mem_stage.sv
data_ram.sv
timer_dev.sv
mips_mem_top.sv
tb_mips_mem.sv
